/* rtl/vdec_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector decode types: opcodes, formats, funct6 codes,
// element widths, unit sub-ops and the control record
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vdec_pkg;

    // Major opcodes of the vector extension, AMO left out
    typedef enum logic [6:0] {
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111
    } vmajoropcode_t;

    // Arithmetic format in funct3
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    // Load/store addressing mode in instr[27:26]
    typedef enum logic [1:0] {
        MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED
    } mop_t;

    // Memory element width field
    typedef enum logic [2:0] {
        WIDTH8  = 3'b000,
        WIDTH16 = 3'b101,
        WIDTH32 = 3'b110
    } width_t;

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } vsew_t;

    // OPI* funct6 codes
    typedef enum logic [5:0] {
        VADD    = 6'b000000, VSUB    = 6'b000010, VRSUB  = 6'b000011,
        VMINU   = 6'b000100, VMIN    = 6'b000101, VMAXU  = 6'b000110,
        VMAX    = 6'b000111, VAND    = 6'b001001, VOR    = 6'b001010,
        VXOR    = 6'b001011, VSLL    = 6'b100101, VSRL   = 6'b101000,
        VSRA    = 6'b101001, VNSRL   = 6'b101100, VNSRA  = 6'b101101,
        VNCLIPU = 6'b101110, VNCLIP  = 6'b101111
    } vopi_t;

    // OPM* funct6 codes
    typedef enum logic [5:0] {
        VREDSUM = 6'b000000, VREDAND   = 6'b000001, VREDOR = 6'b000010,
        VREDXOR = 6'b000011, VWXUNARY0 = 6'b010000, VMAND  = 6'b011001,
        VMOR    = 6'b011010, VMXOR     = 6'b011011, VMULHU = 6'b100100,
        VMUL    = 6'b100101, VMADD     = 6'b101001, VNMSUB = 6'b101011,
        VMACC   = 6'b101101, VNMSAC    = 6'b101111, VWADDU = 6'b110000,
        VWADD   = 6'b110001
    } vopm_t;

    typedef enum logic [2:0] {
        VFU_ALU, VFU_RED, VFU_MSK, VFU_MUL, VFU_PRM
    } vfu_t;

    // Sub-operations per unit, the multiplier reuses valuop for the accumulate sign
    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_RSUB, VALU_MIN, VALU_MAX, VALU_AND,
        VALU_OR, VALU_XOR, VALU_SLL, VALU_SRL, VALU_SRA, VALU_NCLIP
    } valuop_t;

    typedef enum logic [1:0] {VRED_AND, VRED_OR, VRED_XOR, VRED_SUM} vredop_t;
    typedef enum logic [1:0] {VMSK_AND, VMSK_OR, VMSK_XOR} vmaskop_t;
    typedef enum logic [1:0] {VPRM_CPS, VPRM_SLU, VPRM_SLD, VPRM_GTR} vpermop_t;

    typedef struct packed {
        vfu_t     vfu;
        valuop_t  valuop;
        vredop_t  vredop;
        vmaskop_t vmaskop;
        vpermop_t vpermop;
        logic     vopunsigned;
    } vexec_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_t;
    typedef enum logic {RC_SCALAR, RC_VECTOR} regclass_t;

    typedef struct packed {
        regclass_t  regclass;
        logic [4:0] regidx;
    } regsel_t;

    // Micro-op fields sized for up to 8 lanes
    typedef struct packed {
        logic        vmask_en;
        vsetvl_t     vsetvl_type;
        logic [10:0] vtype_imm;
        logic        vkeepvl;
        regsel_t     vd_sel;
        regsel_t     vs1_sel;
        regsel_t     vs2_sel;
        logic        sregwen;
        logic        vregwen;
        logic        vxin1_use_imm;
        logic        vxin1_use_rs1;
        logic        vxin2_use_rs2;
        vsew_t       veew_src1;
        vsew_t       veew_src2;
        vsew_t       veew_dest;
        vexec_t      vexec;
        logic        vmemdren;
        logic        vmemdwen;
        logic        vunitstride;
        logic        vstrided;
        logic        vindexed;
        logic [5:0]  vuop_num;
        logic [3:0]  vbank_offset;
        logic [7:0]  vlaneactive;
    } vcontrol_t;

endpackage

/* rtl/vuop_gen_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoder to micro-op generator link
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface vuop_gen_if
    import vdec_pkg::*;
();
    // Request side, held steady while busy
    logic        gen;
    logic        stall;
    vsew_t       veew;
    logic [6:0]  vl;

    // Current micro-op
    logic [5:0]  vuop_num;
    logic [3:0]  vbank_offset;
    logic [2:0]  vreg_offset;
    logic [7:0]  vlane_active;
    logic        busy;

    modport decoder (
        output gen, stall, veew, vl,
        input  vuop_num, vbank_offset, vreg_offset, vlane_active, busy
    );

    modport generator (
        input  gen, stall, veew, vl,
        output vuop_num, vbank_offset, vreg_offset, vlane_active, busy
    );

endinterface

/* rtl/vopi_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPI* funct6 to execution controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vopi_decode
    import vdec_pkg::*;
(
    input  vopi_t  vopi,
    output vexec_t vexec,
    output logic   valid
);

    always_comb begin
        // Integer ALU unless the code says otherwise
        vexec.vfu         = VFU_ALU;
        vexec.valuop      = VALU_ADD;
        vexec.vredop      = VRED_AND;
        vexec.vmaskop     = VMSK_AND;
        vexec.vpermop     = VPRM_CPS;
        vexec.vopunsigned = 1'b0;
        valid             = 1'b1;

        case (vopi)
            VADD:  vexec.valuop = VALU_ADD;
            VSUB:  vexec.valuop = VALU_SUB;
            VRSUB: vexec.valuop = VALU_RSUB;
            VMINU: begin
                vexec.valuop      = VALU_MIN;
                vexec.vopunsigned = 1'b1;
            end
            VMIN:  vexec.valuop = VALU_MIN;
            VMAXU: begin
                vexec.valuop      = VALU_MAX;
                vexec.vopunsigned = 1'b1;
            end
            VMAX:  vexec.valuop = VALU_MAX;
            VAND:  vexec.valuop = VALU_AND;
            VOR:   vexec.valuop = VALU_OR;
            VXOR:  vexec.valuop = VALU_XOR;
            VSLL:  vexec.valuop = VALU_SLL;
            // Logical right shifts zero fill
            VSRL, VNSRL: begin
                vexec.valuop      = VALU_SRL;
                vexec.vopunsigned = 1'b1;
            end
            VSRA, VNSRA: vexec.valuop = VALU_SRA;
            VNCLIPU: begin
                vexec.valuop      = VALU_NCLIP;
                vexec.vopunsigned = 1'b1;
            end
            VNCLIP: vexec.valuop = VALU_NCLIP;
            default: valid = 1'b0;
        endcase
    end

endmodule

/* rtl/vopm_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// OPM* funct6 to execution controls
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vopm_decode
    import vdec_pkg::*;
(
    input  vopm_t  vopm,
    output vexec_t vexec,
    output logic   valid
);

    always_comb begin
        vexec.vfu         = VFU_ALU;
        vexec.valuop      = VALU_ADD;
        vexec.vredop      = VRED_AND;
        vexec.vmaskop     = VMSK_AND;
        vexec.vpermop     = VPRM_CPS;
        vexec.vopunsigned = 1'b0;
        valid             = 1'b1;

        case (vopm)
            // Reductions
            VREDSUM: begin
                vexec.vfu    = VFU_RED;
                vexec.vredop = VRED_SUM;
            end
            VREDAND: vexec.vfu = VFU_RED;
            VREDOR: begin
                vexec.vfu    = VFU_RED;
                vexec.vredop = VRED_OR;
            end
            VREDXOR: begin
                vexec.vfu    = VFU_RED;
                vexec.vredop = VRED_XOR;
            end
            // Mask logicals
            VMAND: vexec.vfu = VFU_MSK;
            VMOR: begin
                vexec.vfu     = VFU_MSK;
                vexec.vmaskop = VMSK_OR;
            end
            VMXOR: begin
                vexec.vfu     = VFU_MSK;
                vexec.vmaskop = VMSK_XOR;
            end
            // Element copy to a scalar register
            VWXUNARY0: vexec.vfu = VFU_PRM;
            // Multiplier, SUB marks the negated accumulate forms
            VMUL, VMACC, VMADD: vexec.vfu = VFU_MUL;
            VMULHU: begin
                vexec.vfu         = VFU_MUL;
                vexec.vopunsigned = 1'b1;
            end
            VNMSAC, VNMSUB: begin
                vexec.vfu    = VFU_MUL;
                vexec.valuop = VALU_SUB;
            end
            // Widening adds run on the ALU
            VWADDU: vexec.vopunsigned = 1'b1;
            VWADD:  vexec.valuop = VALU_ADD;
            default: valid = 1'b0;
        endcase
    end

endmodule

/* rtl/vuop_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Micro-op sequencer: counter, offsets, lane mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vuop_gen
    import vdec_pkg::*;
#(
    parameter int VLEN      = 128,
    parameter int NUM_LANES = 2
) (
    input logic              CLK,
    input logic              rst_n,
    vuop_gen_if.generator    vug
);

    localparam int LANE_SHIFT = $clog2(NUM_LANES);
    localparam int VLEN_SHIFT = $clog2(VLEN);

    // Counter one bit wider than vuop_num so vl=127 with one lane fits
    logic [6:0] uop_cnt;
    logic [6:0] uop_total;
    logic [7:0] vl_round;
    logic [7:0] first_elem;
    logic [7:0] bank_elem;
    logic [3:0] epr_shift;
    logic       is_last;

    always_comb begin
        // ceil(vl / NUM_LANES), at least one micro-op
        vl_round  = {1'b0, vug.vl} + 8'(NUM_LANES - 1);
        uop_total = (vug.vl == '0) ? 7'd1 : 7'(vl_round >> LANE_SHIFT);
        is_last   = (uop_cnt == uop_total - 7'd1);

        // First element of this micro-op
        first_elem = {1'b0, uop_cnt} << LANE_SHIFT;

        // log2 of elements per register for the destination width
        epr_shift = 4'(VLEN_SHIFT - 3 - int'(vug.veew));
        bank_elem = first_elem & ((8'd1 << epr_shift) - 8'd1);

        vug.vuop_num     = uop_cnt[5:0];
        vug.vreg_offset  = 3'(first_elem >> epr_shift);
        vug.vbank_offset = 4'(bank_elem >> LANE_SHIFT);

        // Lanes past vl or past NUM_LANES stay idle
        for (int i = 0; i < 8; i++) begin
            vug.vlane_active[i] = (i < NUM_LANES) &&
                                  ((int'(first_elem) + i) < int'(vug.vl));
        end

        // Stall on the last micro-op keeps busy up so upstream waits for the advance
        vug.busy = vug.gen && (!is_last || vug.stall);
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            uop_cnt <= '0;
        end else if (!vug.gen) begin
            uop_cnt <= '0;
        end else if (!vug.stall) begin
            // Wrap after the last micro-op
            if (is_last) begin
                uop_cnt <= '0;
            end else begin
                uop_cnt <= uop_cnt + 7'd1;
            end
        end
    end

    // Counter stays inside the micro-op count of the held instruction
    a_cnt_in_range: assert property (@(posedge CLK) disable iff (!rst_n)
        vug.gen |-> (uop_cnt < uop_total));

    // Upstream keeps gen up while the sequence is busy
    a_gen_held: assert property (@(posedge CLK) disable iff (!rst_n)
        vug.busy |=> vug.gen);

endmodule

/* rtl/vector_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector instruction decode stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vector_decode
    import vdec_pkg::*;
#(
    parameter int VLEN      = 128,
    parameter int NUM_LANES = 2
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  vsew_t       vsew,
    input  logic [6:0]  vl,
    input  logic        stall,
    output vcontrol_t   vcontrol,
    output logic        vvalid,
    output logic        vbusy
);

    logic [4:0] rd, rs1, rs2;
    logic [5:0] vfunct6;
    vfunct3_t   vfunct3;
    mop_t       mop;
    width_t     vmem_width;
    logic       is_load, is_store, is_alu, is_cfg;
    logic       vmeminstr, vunitstride, vstrided, vindexed;
    logic       vwidening, vnarrowing, sregwen;
    vsew_t      vmem_eew, twice_vsew, veew_dest;
    vexec_t     vexec_opi, vexec_opm;
    logic       vopi_valid, vopm_valid, vopi_ok, vopm_ok;
    logic [4:0] grp_off;

    vuop_gen_if vug ();

    // Fixed instruction fields
    assign rd         = instr[11:7];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign vfunct3    = vfunct3_t'(instr[14:12]);
    assign vmem_width = width_t'(instr[14:12]);
    assign vfunct6    = instr[31:26];
    assign mop        = mop_t'(instr[27:26]);

    // Major opcode class
    assign is_load  = (instr[6:0] == VMOC_LOAD);
    assign is_store = (instr[6:0] == VMOC_STORE);
    assign is_alu   = (instr[6:0] == VMOC_ALU_CFG);
    assign is_cfg   = is_alu && (vfunct3 == OPCFG);
    assign vvalid   = is_load || is_store || is_alu;

    // Addressing mode only counts for memory ops
    assign vmeminstr   = is_load || is_store;
    assign vunitstride = vmeminstr && (mop == MOP_UNIT);
    assign vstrided    = vmeminstr && (mop == MOP_STRIDED);
    assign vindexed    = vmeminstr && (mop == MOP_UINDEXED || mop == MOP_OINDEXED);

    // Operation decoders, qualified by the format here
    vopi_decode u_vopi (.vopi(vopi_t'(vfunct6)), .vexec(vexec_opi), .valid(vopi_valid));
    vopm_decode u_vopm (.vopm(vopm_t'(vfunct6)), .vexec(vexec_opm), .valid(vopm_valid));

    assign vopi_ok = vopi_valid && is_alu &&
                     (vfunct3 == OPIVV || vfunct3 == OPIVX || vfunct3 == OPIVI);
    assign vopm_ok = vopm_valid && is_alu && (vfunct3 == OPMVV || vfunct3 == OPMVX);

    // Scalar result for vset* and vmv.x.s class
    assign sregwen = is_cfg ||
                     (is_alu && vfunct3 == OPMVV && vfunct6 == VWXUNARY0);

    // Element widths
    assign vmem_eew   = (vmem_width == WIDTH8)  ? SEW8 :
                        (vmem_width == WIDTH16) ? SEW16 : SEW32;
    assign twice_vsew = (vsew == SEW8) ? SEW16 : SEW32;
    assign vwidening  = is_alu && !is_cfg && (vfunct6[5:4] == 2'b11);
    assign vnarrowing = vopi_ok && (vfunct6[5:2] == 4'b1011);

    // Indexed data follows vsew, strided data follows the width field
    assign veew_dest = (vunitstride || vstrided) ? vmem_eew :
                       vindexed                  ? vsew :
                       vwidening                 ? twice_vsew : vsew;

    // Micro-op generator
    assign vug.gen   = vvalid;
    assign vug.stall = stall;
    assign vug.veew  = veew_dest;
    assign vug.vl    = vl;
    assign vbusy     = vug.busy;
    assign grp_off   = {2'b00, vug.vreg_offset};

    vuop_gen #(.VLEN(VLEN), .NUM_LANES(NUM_LANES)) u_vuop_gen (
        .CLK   (CLK),
        .rst_n (rst_n),
        .vug   (vug)
    );

    always_comb begin
        vcontrol.vmask_en = !instr[25];

        // vset* class from the top two bits
        vcontrol.vsetvl_type = NOT_CFG;
        vcontrol.vtype_imm   = '0;
        vcontrol.vkeepvl     = 1'b0;
        if (is_cfg) begin
            casez (instr[31:30])
                2'b0?: begin
                    vcontrol.vsetvl_type = VSETVLI;
                    vcontrol.vtype_imm   = instr[30:20];
                    vcontrol.vkeepvl     = (rs1 == '0) && (rd == '0);
                end
                2'b11: begin
                    vcontrol.vsetvl_type = VSETIVLI;
                    vcontrol.vtype_imm   = {1'b0, instr[29:20]};
                end
                default: begin
                    vcontrol.vsetvl_type = VSETVL;
                    vcontrol.vkeepvl     = (rs1 == '0) && (rd == '0);
                end
            endcase
        end

        // Group offset steps through the register group, scalar rd stays put
        vcontrol.vd_sel.regclass  = sregwen ? RC_SCALAR : RC_VECTOR;
        vcontrol.vd_sel.regidx    = sregwen ? rd : rd + grp_off;
        // Stores carry vs3 in the rd field
        vcontrol.vs1_sel.regclass = RC_VECTOR;
        vcontrol.vs1_sel.regidx   = (is_store ? rd : rs1) + grp_off;
        vcontrol.vs2_sel.regclass = RC_VECTOR;
        vcontrol.vs2_sel.regidx   = rs2 + grp_off;

        vcontrol.sregwen = sregwen;
        vcontrol.vregwen = !sregwen && !is_store;

        // Operand selects
        vcontrol.vxin1_use_imm = is_alu && (vfunct3 == OPIVI);
        vcontrol.vxin1_use_rs1 = vmeminstr || (is_alu && (vfunct3 == OPIVX ||
                                 vfunct3 == OPFVF || vfunct3 == OPMVX));
        vcontrol.vxin2_use_rs2 = vmeminstr && !vindexed;

        // Indexed address offsets in vs2 use the width field
        vcontrol.veew_src1 = vsew;
        vcontrol.veew_src2 = vindexed   ? vmem_eew :
                             vnarrowing ? twice_vsew : vsew;
        vcontrol.veew_dest = veew_dest;

        // Memory address math is an unsigned ALU add
        vcontrol.vexec = vexec_opi;
        if (vopm_ok) begin
            vcontrol.vexec = vexec_opm;
        end else if (vmeminstr) begin
            vcontrol.vexec.vfu         = VFU_ALU;
            vcontrol.vexec.valuop      = VALU_ADD;
            vcontrol.vexec.vopunsigned = 1'b1;
        end

        vcontrol.vmemdren    = is_load;
        vcontrol.vmemdwen    = is_store;
        vcontrol.vunitstride = vunitstride;
        vcontrol.vstrided    = vstrided;
        vcontrol.vindexed    = vindexed;

        vcontrol.vuop_num     = vug.vuop_num;
        vcontrol.vbank_offset = vug.vbank_offset;
        vcontrol.vlaneactive  = vug.vlane_active;
    end

    // OPI, OPM and memory paths never claim the same instruction
    a_one_exec_src: assert property (@(posedge CLK) disable iff (!rst_n)
        vvalid |-> $onehot0({vopi_ok, vopm_ok, vmeminstr}));

endmodule

/* rtl/vector_decode_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode stage top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vector_decode_top
    import vdec_pkg::*;
#(
    parameter int VLEN      = 128,
    // One of 1, 2, 4 or 8
    parameter int NUM_LANES = 2
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  vsew_t       vsew,
    input  logic [6:0]  vl,
    input  logic        stall,
    output vcontrol_t   vcontrol,
    output logic        vvalid,
    output logic        vbusy
);

    // Decode is combinational, the sequence counter is the only state
    vector_decode #(
        .VLEN      (VLEN),
        .NUM_LANES (NUM_LANES)
    ) u_vector_decode (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .instr    (instr),
        .vsew     (vsew),
        .vl       (vl),
        .stall    (stall),
        .vcontrol (vcontrol),
        .vvalid   (vvalid),
        .vbusy    (vbusy)
    );

endmodule

/* test/vdec_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode field compare, expected micro-op
// sequence model and per-test reporting
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module vdec_checker
    import vdec_pkg::*;
#(
    parameter int VLEN      = 128,
    parameter int NUM_LANES = 2
) (
    input  logic         CLK,
    input  logic         rst_n,
    input  int           test_id,
    input  logic [127:0] test_name,
    input  int           exp_f [14],
    input  logic [31:0]  instr,
    input  logic [6:0]   vl,
    input  logic         stall,
    input  vcontrol_t    vcontrol,
    input  logic         vvalid,
    input  logic         vbusy,
    output int           err_count,
    output int           tests_done,
    output int           tests_failed
);

    // Column positions of the expected record
    localparam int F_VVALID   = 0;
    localparam int F_VSET     = 1;
    localparam int F_IMM      = 2;
    localparam int F_KEEPVL   = 3;
    localparam int F_SREGWEN  = 4;
    localparam int F_VREGWEN  = 5;
    localparam int F_EEW_DEST = 6;
    localparam int F_EEW_SRC2 = 7;
    localparam int F_VFU      = 8;
    localparam int F_VALUOP   = 9;
    localparam int F_DREN     = 10;
    localparam int F_DWEN     = 11;
    localparam int F_MODE     = 12;
    localparam int F_RS2      = 13;

    int           cur_id;
    int           k;
    int           test_err;
    bit           active;
    logic [127:0] cur_name;

    task automatic check_val(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("FAILED %0s %0s expected %0d actual %0d", cur_name, what, exp, act);
            test_err++;
            err_count++;
        end
    endtask

    // Micro-op count is ceil(vl / lanes) and one for vl of zero
    function automatic int uop_total();
        if (vl == '0) begin
            return 1;
        end
        return (int'(vl) + NUM_LANES - 1) / NUM_LANES;
    endfunction

    // Combinational decode fields stay constant over the instruction
    task automatic check_decode();
        check_val("vvalid", exp_f[F_VVALID], int'(vvalid));
        if (exp_f[F_VVALID] != 0) begin
            check_val("vsetvl_type", exp_f[F_VSET], int'(vcontrol.vsetvl_type));
            check_val("vtype_imm", exp_f[F_IMM], int'(vcontrol.vtype_imm));
            check_val("vkeepvl", exp_f[F_KEEPVL], int'(vcontrol.vkeepvl));
            check_val("sregwen", exp_f[F_SREGWEN], int'(vcontrol.sregwen));
            check_val("vregwen", exp_f[F_VREGWEN], int'(vcontrol.vregwen));
            check_val("veew_dest", exp_f[F_EEW_DEST], int'(vcontrol.veew_dest));
            check_val("veew_src2", exp_f[F_EEW_SRC2], int'(vcontrol.veew_src2));
            check_val("vfu", exp_f[F_VFU], int'(vcontrol.vexec.vfu));
            check_val("valuop", exp_f[F_VALUOP], int'(vcontrol.vexec.valuop));
            check_val("vmemdren", exp_f[F_DREN], int'(vcontrol.vmemdren));
            check_val("vmemdwen", exp_f[F_DWEN], int'(vcontrol.vmemdwen));
            check_val("vunitstride", int'(exp_f[F_MODE] == 1), int'(vcontrol.vunitstride));
            check_val("vstrided", int'(exp_f[F_MODE] == 2), int'(vcontrol.vstrided));
            check_val("vindexed", int'(exp_f[F_MODE] == 3), int'(vcontrol.vindexed));
            check_val("vxin2_use_rs2", exp_f[F_RS2], int'(vcontrol.vxin2_use_rs2));
            // Mask enable comes from the vm bit outside vset*
            if (exp_f[F_VSET] == 0) begin
                check_val("vmask_en", int'(!instr[25]), int'(vcontrol.vmask_en));
            end
        end
    endtask

    // Expected first element, register group step, bank and lanes of micro-op k
    task automatic check_uop();
        int         e;
        int         epr;
        int         reg_off;
        int         vs1_idx;
        logic [7:0] mask;
        e       = k * NUM_LANES;
        epr     = VLEN / (8 << exp_f[F_EEW_DEST]);
        reg_off = e / epr;
        mask    = '0;
        for (int i = 0; i < 8; i++) begin
            if (i < NUM_LANES && (e + i) < int'(vl)) begin
                mask[i] = 1'b1;
            end
        end
        check_val("vuop_num", k, int'(vcontrol.vuop_num));
        check_val("vbank_offset", (e % epr) / NUM_LANES, int'(vcontrol.vbank_offset));
        check_val("vlaneactive", int'(mask), int'(vcontrol.vlaneactive));
        if (exp_f[F_SREGWEN] == 0) begin
            check_val("vd_sel", (int'(instr[11:7]) + reg_off) % 32,
                      int'(vcontrol.vd_sel.regidx));
        end
        // Stores read vs3 from the rd field
        vs1_idx = (exp_f[F_DWEN] != 0) ? int'(instr[11:7]) : int'(instr[19:15]);
        check_val("vs1_sel", (vs1_idx + reg_off) % 32, int'(vcontrol.vs1_sel.regidx));
        check_val("vs2_sel", (int'(instr[24:20]) + reg_off) % 32,
                  int'(vcontrol.vs2_sel.regidx));
        // Busy stays up on the last micro-op only while stalled
        check_val("vbusy", int'(k != uop_total() - 1 || stall), int'(vbusy));
    endtask

    task automatic finish_test();
        if (test_err == 0) begin
            $display("%0s: ok", cur_name);
        end else begin
            $display("%0s: %0d mismatches", cur_name, test_err);
            tests_failed++;
        end
        tests_done++;
        active = 1'b0;
    endtask

    always @(negedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            cur_id       = 0;
            k            = 0;
            test_err     = 0;
            active       = 1'b0;
            cur_name     = '0;
            err_count    = 0;
            tests_done   = 0;
            tests_failed = 0;
        end else begin
            // New instruction on the ports
            if (test_id != cur_id) begin
                if (active) begin
                    $display("test %0s was replaced before its last micro-op", cur_name);
                    err_count++;
                    tests_failed++;
                    tests_done++;
                end
                cur_id   = test_id;
                cur_name = test_name;
                k        = 0;
                test_err = 0;
                active   = 1'b1;
                check_decode();
            end
            if (active) begin
                if (exp_f[F_VVALID] == 0) begin
                    check_val("vbusy", 0, int'(vbusy));
                    finish_test();
                end else begin
                    check_uop();
                    // Stall holds the current micro-op
                    if (!stall) begin
                        if (k == uop_total() - 1) begin
                            finish_test();
                        end else begin
                            k++;
                        end
                    end
                end
            end
        end
    end

endmodule

/* test/tb_vector_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vector decode testbench: clock, reset, file reader, driver
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_vector_decode
    import vdec_pkg::*;
();

    localparam int VLEN      = 128;
    localparam int NUM_LANES = 2;
    localparam int TIMEOUT   = 200;

    logic         CLK;
    logic         rst_n;
    logic [31:0]  instr;
    vsew_t        vsew;
    logic [6:0]   vl;
    logic         stall;
    vcontrol_t    vcontrol;
    logic         vvalid;
    logic         vbusy;

    int           test_id;
    logic [127:0] test_name;
    int           exp_f [14];
    int           err_count;
    int           tests_done;
    int           tests_failed;

    int           seed;
    int           fd;
    int           ntests;
    bit           timed_out;
    bit           open_failed;

    vector_decode_top #(.VLEN(VLEN), .NUM_LANES(NUM_LANES)) UUT (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .instr    (instr),
        .vsew     (vsew),
        .vl       (vl),
        .stall    (stall),
        .vcontrol (vcontrol),
        .vvalid   (vvalid),
        .vbusy    (vbusy)
    );

    vdec_checker #(.VLEN(VLEN), .NUM_LANES(NUM_LANES)) u_checker (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .test_id      (test_id),
        .test_name    (test_name),
        .exp_f        (exp_f),
        .instr        (instr),
        .vl           (vl),
        .stall        (stall),
        .vcontrol     (vcontrol),
        .vvalid       (vvalid),
        .vbusy        (vbusy),
        .err_count    (err_count),
        .tests_done   (tests_done),
        .tests_failed (tests_failed)
    );

    // 8 ns period
    always #4 CLK = ~CLK;

    // Coin flip per cycle for tests that allow stall
    function automatic logic next_stall(input int en);
        int r;
        r = $random(seed);
        return (en != 0) && r[0];
    endfunction

    // Hold the instruction until the last micro-op, checked at mid cycle
    task automatic wait_idle(input int en);
        int waited;
        waited = 0;
        @(negedge CLK);
        while (vbusy && !timed_out) begin
            if (waited == TIMEOUT) begin
                $display("timeout: vbusy stayed high for %0d cycles in test %0s",
                         TIMEOUT, test_name);
                timed_out = 1'b1;
            end else begin
                waited++;
                @(posedge CLK);
                stall <= next_stall(en);
                @(negedge CLK);
            end
        end
    endtask

    task automatic run_file();
        string        line;
        logic [127:0] name_buf;
        int           row [18];
        int           code;
        int           n;
        while (!$feof(fd) && !timed_out) begin
            line = "";
            code = $fgets(line, fd);
            // Skip blank and comment lines
            if (code > 0 && line.len() > 1 && line[0] != 8'h23) begin
                n = $sscanf(line,
                    "%s %h %d %d %d %d %d %h %d %d %d %d %d %d %d %d %d %d %d",
                    name_buf, row[0], row[1], row[2], row[3], row[4], row[5],
                    row[6], row[7], row[8], row[9], row[10], row[11], row[12],
                    row[13], row[14], row[15], row[16], row[17]);
                if (n == 19) begin
                    ntests++;
                    @(posedge CLK);
                    instr     <= row[0];
                    vsew      <= vsew_t'(row[1][1:0]);
                    vl        <= row[2][6:0];
                    stall     <= next_stall(row[3]);
                    test_name <= name_buf;
                    test_id   <= test_id + 1;
                    for (int i = 0; i < 14; i++) begin
                        exp_f[i] <= row[i + 4];
                    end
                    wait_idle(row[3]);
                end else begin
                    $display("malformed line in test data: %0s", line);
                end
            end
        end
    endtask

    initial begin
        CLK         = 1'b0;
        rst_n       = 1'b0;
        instr       = '0;
        vsew        = SEW8;
        vl          = '0;
        stall       = 1'b0;
        test_id     = 0;
        test_name   = '0;
        seed        = 32'hf87e;
        ntests      = 0;
        timed_out   = 1'b0;
        open_failed = 1'b0;
        for (int i = 0; i < 14; i++) begin
            exp_f[i] = 0;
        end

        repeat (4) @(posedge CLK);
        rst_n <= 1'b1;

        fd = $fopen("test/testdata_vdec.txt", "r");
        if (fd == 0) begin
            $display("could not open test/testdata_vdec.txt");
            open_failed = 1'b1;
        end else begin
            run_file();
            $fclose(fd);
        end

        // Idle opcode so the checker sees the last test finish
        @(posedge CLK);
        instr <= '0;
        stall <= 1'b0;
        repeat (2) @(negedge CLK);

        $display("tests %0d, finished %0d, failed %0d, mismatches %0d",
                 ntests, tests_done, tests_failed, err_count);
        if (!open_failed && !timed_out && ntests > 0 && err_count == 0 &&
            tests_done == ntests) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
rtl/vdec_pkg.sv
rtl/vuop_gen_if.sv
rtl/vopi_decode.sv
rtl/vopm_decode.sv
rtl/vuop_gen.sv
rtl/vector_decode.sv
rtl/vector_decode_top.sv
test/vdec_checker.sv
test/tb_vector_decode.sv

/* run_sim.sh */
#!/bin/sh
# Build the vector decode testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_vector_decode \
    -o sim_vdec

out=$(./obj_dir/sim_vdec)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
else
    exit 1
fi

/* test/testdata_vdec.txt */
# name instr vsew vl stall | vvalid vset imm keepvl sregwen vregwen eew_dest eew_src2
# vfu valuop dren dwen mode(0 none 1 unit 2 strided 3 indexed) use_rs2
non_vector    00100093 0 4  0 0 0 000 0 0 1 0 0 0 0  0 0 0 0
non_vec_stall 00100093 1 2  1 0 0 000 0 0 1 0 0 0 0  0 0 0 0
vsetvli_x5    008572D7 0 3  0 1 1 008 0 1 0 0 0 0 0  0 0 0 0
vsetvli_keep  01007057 0 2  0 1 1 010 1 1 0 0 0 0 0  0 0 0 0
vsetivli      CC027357 0 4  0 1 2 0C0 0 1 0 0 0 0 0  0 0 0 0
vsetivli_zero CC007057 0 1  0 1 2 0C0 0 1 0 0 0 0 0  0 0 0 0
vsetvl_keep   80307057 0 1  0 1 3 000 1 1 0 0 0 0 0  0 0 0 0
vadd_vl16     02860257 2 16 0 1 0 000 0 0 1 2 2 0 0  0 0 0 0
vadd_vl5      02860257 1 5  0 1 0 000 0 0 1 1 1 0 0  0 0 0 0
vadd_vl1      02860257 0 1  0 1 0 000 0 0 1 0 0 0 0  0 0 0 0
vadd_vl0      02860257 0 0  0 1 0 000 0 0 1 0 0 0 0  0 0 0 0
vsub_vx       0A62C157 0 4  0 1 0 000 0 0 1 0 0 0 1  0 0 0 0
vminu_vv      128180D7 1 3  0 1 0 000 0 0 1 1 1 0 3  0 0 0 0
vsra_vi       A640B457 2 8  0 1 0 000 0 0 1 2 2 0 10 0 0 0 0
vnsrl_wv      B2430157 0 16 0 1 0 000 0 0 1 0 1 0 9  0 0 0 0
vredsum       02822157 1 8  0 1 0 000 0 0 1 1 1 1 0  0 0 0 0
vmand         6621A0D7 0 16 0 1 0 000 0 0 1 0 0 2 0  0 0 0 0
vmul          96822657 2 5  0 1 0 000 0 0 1 2 2 3 0  0 0 0 0
vnmsac        BE822657 2 6  0 1 0 000 0 0 1 2 2 3 1  0 0 0 0
vmv_x_s       42402557 2 1  0 1 0 000 0 1 0 2 2 4 0  0 0 0 0
vwaddu_vv     C2822857 0 16 0 1 0 000 0 0 1 1 0 0 0  0 0 0 0
vwadd_stall   C682E857 1 9  1 1 0 000 0 0 1 2 1 0 0  0 0 0 0
vadd_stall    02860257 0 31 1 1 0 000 0 0 1 0 0 0 0  0 0 0 0
vle32         02056207 0 12 0 1 0 000 0 0 1 2 0 0 0  1 0 1 1
vlse16        0AC5D407 0 7  0 1 0 000 0 0 1 1 0 0 0  1 0 2 1
vluxei8       06650107 2 5  0 1 0 000 0 0 1 2 0 0 0  1 0 3 0
vse8          020501A7 1 5  0 1 0 000 0 0 0 0 1 0 0  0 1 1 1
vsoxei32      0E8561A7 1 9  1 1 0 000 0 0 0 1 2 0 0  0 1 3 0
